// File: verilog/ddr3_pkg.sv
package ddr3_pkg;

  localparam int ADDR_W         = 28;
  localparam int WORD_W         = 32;
  localparam int SEL_W          = WORD_W / 8;
  localparam int LINE_W         = 128;
  localparam int LINE_BYTES     = LINE_W / 8;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);
  localparam int OFFS_W         = $clog2(LINE_BYTES);  // byte offset inside a line.
  localparam int AVL_ADDR_W     = 26;                   // one avalon word per line.

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [WORD_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [WORD_W-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [AVL_ADDR_W-1:0] addr;
    logic [LINE_W-1:0]     wdata;
    logic [LINE_BYTES-1:0] be;
  } line_req_t;

  typedef struct packed {
    logic              done;
    logic [LINE_W-1:0] rdata;
  } line_rsp_t;

  typedef enum logic [1:0] {ARB_IDLE, ARB_BUSY, ARB_RESP} arb_state_t;

  typedef enum logic [1:0] {AVL_IDLE, AVL_CMD, AVL_WAIT} avl_state_t;

endpackage

// File: verilog/line_cache.sv
module line_cache #(
  parameter int LINES    = 16,
  parameter bit WRITABLE = 1'b1
) (
  input  logic                clk,
  input  logic                rst,
  input  ddr3_pkg::wb_req_t   wb_i,
  output ddr3_pkg::wb_rsp_t   wb_o,
  output ddr3_pkg::line_req_t line_o,
  input  ddr3_pkg::line_rsp_t line_i
);
  import ddr3_pkg::*;

  localparam int IDX_W = $clog2(LINES);
  localparam int TAG_W = ADDR_W - OFFS_W - IDX_W;

  logic [TAG_W-1:0]  tag_mem  [LINES];
  logic [LINE_W-1:0] data_mem [LINES];
  logic [LINES-1:0]  vld_mem;

  // lookup stage.
  logic              lk_q;
  logic              lk_we;
  logic [ADDR_W-1:0] lk_adr;
  logic [WORD_W-1:0] lk_dat;
  logic [SEL_W-1:0]  lk_sel;
  logic [TAG_W-1:0]  lk_tag;
  logic              lk_vld;
  logic [LINE_W-1:0] lk_line;

  logic                  accept;
  logic [IDX_W-1:0]      req_idx;
  logic [IDX_W-1:0]      lk_idx;
  logic [WORD_IDX_W-1:0] lk_word;
  logic                  lk_hit;
  logic [LINE_W-1:0]     wdata_lane;
  logic [LINE_BYTES-1:0] be_lane;

  // one request at a time; stb stays up until the cycle after ack.
  assign accept  = wb_i.cyc & wb_i.stb & ~lk_q & ~line_o.valid & ~wb_o.ack;
  assign req_idx = wb_i.adr[OFFS_W +: IDX_W];
  assign lk_idx  = lk_adr[OFFS_W +: IDX_W];
  assign lk_word = lk_adr[OFFS_W-1 -: WORD_IDX_W];
  assign lk_hit  = lk_vld & (lk_tag == lk_adr[ADDR_W-1 -: TAG_W]);

  assign wdata_lane = {WORDS_PER_LINE{lk_dat}};
  assign be_lane    = LINE_BYTES'(lk_sel) << (lk_word * SEL_W);  // sel moved to its lane.

  always_ff @(posedge clk)
  begin
    wb_o.ack <= 1'b0;

    if (accept)
    begin
      lk_q    <= 1'b1;
      lk_we   <= wb_i.we;
      lk_adr  <= wb_i.adr;
      lk_dat  <= wb_i.dat;
      lk_sel  <= wb_i.sel;
      lk_tag  <= tag_mem[req_idx];
      lk_vld  <= vld_mem[req_idx];
      lk_line <= data_mem[req_idx];
    end

    if (lk_q)
    begin
      lk_q <= 1'b0;
      if (lk_we && !WRITABLE)
      begin
        wb_o.ack <= 1'b1;  // instruction port drops writes.
      end
      else if (!lk_we && lk_hit)
      begin
        wb_o.ack <= 1'b1;
        wb_o.dat <= lk_line[lk_word*WORD_W +: WORD_W];
      end
      else
      begin
        line_o.valid <= 1'b1;
        line_o.we    <= lk_we;
        line_o.addr  <= AVL_ADDR_W'(lk_adr[ADDR_W-1:OFFS_W]);
        line_o.wdata <= wdata_lane;
        line_o.be    <= lk_we ? be_lane : '0;
      end
    end

    if (line_o.valid && line_i.done)
    begin
      line_o.valid <= 1'b0;
      wb_o.ack     <= 1'b1;
      if (line_o.we)
      begin
        if (lk_hit)
        begin
          for (int b = 0; b < LINE_BYTES; b++)
          begin
            if (line_o.be[b])
            begin
              data_mem[lk_idx][b*8 +: 8] <= line_o.wdata[b*8 +: 8];
            end
          end
        end
      end
      else
      begin
        data_mem[lk_idx] <= line_i.rdata;  // fill.
        tag_mem[lk_idx]  <= lk_adr[ADDR_W-1 -: TAG_W];
        vld_mem[lk_idx]  <= 1'b1;
        wb_o.dat         <= line_i.rdata[lk_word*WORD_W +: WORD_W];
      end
    end

    if (rst)
    begin
      lk_q         <= 1'b0;
      line_o.valid <= 1'b0;
      wb_o.ack     <= 1'b0;
      vld_mem      <= '0;
    end
  end

endmodule

// File: verilog/line_arbiter.sv
module line_arbiter (
  input  logic                clk,
  input  logic                rst,
  input  ddr3_pkg::line_req_t inst_i,
  output ddr3_pkg::line_rsp_t inst_o,
  input  ddr3_pkg::line_req_t data_i,
  output ddr3_pkg::line_rsp_t data_o,
  output ddr3_pkg::line_req_t mem_o,
  input  ddr3_pkg::line_rsp_t mem_i
);
  import ddr3_pkg::*;

  arb_state_t state;
  logic       last_data;  // data port got the last grant.
  logic       sel_data;   // owner of the open transaction.
  logic       pick_data;

  // round robin only matters when both ask.
  always_comb
  begin
    if (inst_i.valid && data_i.valid)
    begin
      pick_data = ~last_data;
    end
    else
    begin
      pick_data = data_i.valid;
    end
  end

  always_ff @(posedge clk)
  begin
    inst_o.done <= 1'b0;
    data_o.done <= 1'b0;

    case (state)
      ARB_IDLE:
      begin
        if (inst_i.valid || data_i.valid)
        begin
          mem_o     <= pick_data ? data_i : inst_i;
          sel_data  <= pick_data;
          last_data <= pick_data;
          state     <= ARB_BUSY;
        end
      end
      ARB_BUSY:
      begin
        if (mem_i.done)
        begin
          mem_o.valid <= 1'b0;
          if (sel_data)
          begin
            data_o.done  <= 1'b1;
            data_o.rdata <= mem_i.rdata;
          end
          else
          begin
            inst_o.done  <= 1'b1;
            inst_o.rdata <= mem_i.rdata;
          end
          state <= ARB_RESP;
        end
      end
      ARB_RESP:
      begin
        state <= ARB_IDLE;  // owner still shows valid this cycle.
      end
      default:
      begin
        state <= ARB_IDLE;
      end
    endcase

    if (rst)
    begin
      state       <= ARB_IDLE;
      mem_o.valid <= 1'b0;
      inst_o.done <= 1'b0;
      data_o.done <= 1'b0;
      last_data   <= 1'b1;  // instruction port first.
    end
  end

endmodule

// File: verilog/avl_master.sv
module avl_master (
  input  logic                                clk,
  input  logic                                rst,
  input  ddr3_pkg::line_req_t                 req_i,
  output ddr3_pkg::line_rsp_t                 rsp_o,
  input  logic                                avl_ready_i,
  input  logic                                avl_rdata_valid_i,
  input  logic [ddr3_pkg::LINE_W-1:0]         avl_rdata_i,
  output logic                                avl_read_o,
  output logic                                avl_write_o,
  output logic [ddr3_pkg::AVL_ADDR_W-1:0]     avl_addr_o,
  output logic [ddr3_pkg::LINE_W-1:0]         avl_wdata_o,
  output logic [ddr3_pkg::LINE_BYTES-1:0]     avl_be_o
);
  import ddr3_pkg::*;

  avl_state_t state;

  always_ff @(posedge clk)
  begin
    rsp_o.done <= 1'b0;

    case (state)
      AVL_IDLE:
      begin
        // requester still holds valid while done is out.
        if (req_i.valid && !rsp_o.done)
        begin
          avl_read_o  <= ~req_i.we;
          avl_write_o <= req_i.we;
          avl_addr_o  <= req_i.addr;
          avl_wdata_o <= req_i.wdata;
          avl_be_o    <= req_i.we ? req_i.be : '1;
          state       <= AVL_CMD;
        end
      end
      AVL_CMD:
      begin
        if (avl_ready_i)
        begin
          avl_read_o  <= 1'b0;
          avl_write_o <= 1'b0;
          if (avl_write_o)
          begin
            rsp_o.done <= 1'b1;
            state      <= AVL_IDLE;
          end
          else
          begin
            state <= AVL_WAIT;
          end
        end
      end
      AVL_WAIT:
      begin
        if (avl_rdata_valid_i)
        begin
          rsp_o.done  <= 1'b1;
          rsp_o.rdata <= avl_rdata_i;
          state       <= AVL_IDLE;
        end
      end
      default:
      begin
        state <= AVL_IDLE;
      end
    endcase

    if (rst)
    begin
      state       <= AVL_IDLE;
      rsp_o.done  <= 1'b0;
      avl_read_o  <= 1'b0;
      avl_write_o <= 1'b0;
    end
  end

endmodule

// File: verilog/ddr3_frontend.sv
module ddr3_frontend #(
  parameter int INST_LINES = 4,
  parameter int DATA_LINES = 16
) (
  input  logic                            clk,
  input  logic                            rst,
  input  ddr3_pkg::wb_req_t               inst_wb_i,
  output ddr3_pkg::wb_rsp_t               inst_wb_o,
  input  ddr3_pkg::wb_req_t               data_wb_i,
  output ddr3_pkg::wb_rsp_t               data_wb_o,
  input  logic                            avl_ready_i,
  input  logic                            avl_rdata_valid_i,
  input  logic [ddr3_pkg::LINE_W-1:0]     avl_rdata_i,
  output logic                            avl_read_o,
  output logic                            avl_write_o,
  output logic [ddr3_pkg::AVL_ADDR_W-1:0] avl_addr_o,
  output logic [ddr3_pkg::LINE_W-1:0]     avl_wdata_o,
  output logic [ddr3_pkg::LINE_BYTES-1:0] avl_be_o
);
  import ddr3_pkg::*;

  line_req_t inst_line_req;
  line_rsp_t inst_line_rsp;
  line_req_t data_line_req;
  line_rsp_t data_line_rsp;
  line_req_t mem_req;
  line_rsp_t mem_rsp;

  line_cache #(
    .LINES    (INST_LINES),
    .WRITABLE (1'b0)  // read only.
  ) inst_cache (
    .clk    (clk),
    .rst    (rst),
    .wb_i   (inst_wb_i),
    .wb_o   (inst_wb_o),
    .line_o (inst_line_req),
    .line_i (inst_line_rsp)
  );

  line_cache #(
    .LINES    (DATA_LINES),
    .WRITABLE (1'b1)
  ) data_cache (
    .clk    (clk),
    .rst    (rst),
    .wb_i   (data_wb_i),
    .wb_o   (data_wb_o),
    .line_o (data_line_req),
    .line_i (data_line_rsp)
  );

  line_arbiter arbiter (
    .clk    (clk),
    .rst    (rst),
    .inst_i (inst_line_req),
    .inst_o (inst_line_rsp),
    .data_i (data_line_req),
    .data_o (data_line_rsp),
    .mem_o  (mem_req),
    .mem_i  (mem_rsp)
  );

  avl_master master (
    .clk               (clk),
    .rst               (rst),
    .req_i             (mem_req),
    .rsp_o             (mem_rsp),
    .avl_ready_i       (avl_ready_i),
    .avl_rdata_valid_i (avl_rdata_valid_i),
    .avl_rdata_i       (avl_rdata_i),
    .avl_read_o        (avl_read_o),
    .avl_write_o       (avl_write_o),
    .avl_addr_o        (avl_addr_o),
    .avl_wdata_o       (avl_wdata_o),
    .avl_be_o          (avl_be_o)
  );

endmodule

// File: verif/ddr3_frontend_asserts.sv
module ddr3_frontend_asserts (
  input logic                            clk,
  input logic                            rst,
  input ddr3_pkg::wb_rsp_t               inst_wb_i,
  input ddr3_pkg::wb_rsp_t               data_wb_i,
  input ddr3_pkg::line_rsp_t             inst_line_i,
  input ddr3_pkg::line_rsp_t             data_line_i,
  input logic                            avl_read_i,
  input logic                            avl_write_i,
  input logic [ddr3_pkg::AVL_ADDR_W-1:0] avl_addr_i,
  input logic                            avl_ready_i
);

  int fail_cnt = 0;

  inst_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    inst_wb_i.ack |=> !inst_wb_i.ack)
  else
  begin
    $error("instruction port ack high two cycles in a row");
    fail_cnt++;
  end

  data_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    data_wb_i.ack |=> !data_wb_i.ack)
  else
  begin
    $error("data port ack high two cycles in a row");
    fail_cnt++;
  end

  avl_one_cmd: assert property (@(posedge clk) disable iff (rst)
    !(avl_read_i && avl_write_i))
  else
  begin
    $error("avalon read and write asserted together");
    fail_cnt++;
  end

  // command and address held through wait states.
  avl_addr_hold: assert property (@(posedge clk) disable iff (rst)
    (avl_read_i || avl_write_i) && !avl_ready_i |=>
      (avl_read_i || avl_write_i) && $stable(avl_addr_i))
  else
  begin
    $error("avalon command or address changed before ready");
    fail_cnt++;
  end

  one_done: assert property (@(posedge clk) disable iff (rst)
    !(inst_line_i.done && data_line_i.done))
  else
  begin
    $error("arbiter returned done to both ports at once");
    fail_cnt++;
  end

endmodule

// File: verif/ddr3_frontend_tb.sv
module ddr3_frontend_tb;
  import ddr3_pkg::*;

  localparam int PERIOD    = 20;
  localparam int NUM_TESTS = 5;
  localparam int HIT_LAT   = 2;  // cycles from stb sampled to ack.

  logic                  clk;
  logic                  rst;
  wb_req_t               inst_wb;
  wb_rsp_t               inst_rsp;
  wb_req_t               data_wb;
  wb_rsp_t               data_rsp;
  logic                  avl_ready;
  logic                  avl_rdata_valid;
  logic [LINE_W-1:0]     avl_rdata;
  logic                  avl_read;
  logic                  avl_write;
  logic [AVL_ADDR_W-1:0] avl_addr;
  logic [LINE_W-1:0]     avl_wdata;
  logic [LINE_BYTES-1:0] avl_be;

  logic [31:0]           lfsr_state;
  logic [LINE_W-1:0]     mem_model [logic [AVL_ADDR_W-1:0]];
  logic [LINE_W-1:0]     shadow    [logic [AVL_ADDR_W-1:0]];
  logic [AVL_ADDR_W-1:0] rd_addr;
  int                    rd_cnt;
  int                    errors;
  int                    checks;
  int                    err_base;
  int                    chk_base;

  ddr3_frontend #(
    .INST_LINES (4),
    .DATA_LINES (16)
  ) DUT (
    .clk               (clk),
    .rst               (rst),
    .inst_wb_i         (inst_wb),
    .inst_wb_o         (inst_rsp),
    .data_wb_i         (data_wb),
    .data_wb_o         (data_rsp),
    .avl_ready_i       (avl_ready),
    .avl_rdata_valid_i (avl_rdata_valid),
    .avl_rdata_i       (avl_rdata),
    .avl_read_o        (avl_read),
    .avl_write_o       (avl_write),
    .avl_addr_o        (avl_addr),
    .avl_wdata_o       (avl_wdata),
    .avl_be_o          (avl_be)
  );

  bind ddr3_frontend ddr3_frontend_asserts chk (
    .clk         (clk),
    .rst         (rst),
    .inst_wb_i   (inst_wb_o),
    .data_wb_i   (data_wb_o),
    .inst_line_i (inst_line_rsp),
    .data_line_i (data_line_rsp),
    .avl_read_i  (avl_read_o),
    .avl_write_i (avl_write_o),
    .avl_addr_i  (avl_addr_o),
    .avl_ready_i (avl_ready_i)
  );

  always #(PERIOD/2) clk = ~clk;

  // untouched memory reads as a function of the full line address.
  function automatic logic [LINE_W-1:0] fill_pattern(input logic [AVL_ADDR_W-1:0] a);
    logic [31:0] w;
    w = 32'(a);
    return {w ^ 32'h5a5a_0f0f, w * 32'h9e37_79b9, ~w, {w[15:0], w[31:16]} ^ 32'h0ff0_1234};
  endfunction

  function automatic logic [3:0] take_bits(input int n);
    logic [3:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
      r = {r[2:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [LINE_W-1:0] shadow_line(input logic [ADDR_W-1:0] adr);
    logic [AVL_ADDR_W-1:0] la;
    la = AVL_ADDR_W'(adr[ADDR_W-1:OFFS_W]);
    if (!shadow.exists(la))
      shadow[la] = fill_pattern(la);
    return shadow[la];
  endfunction

  // avalon memory model with random stalls and read latency.
  always @(posedge clk)
  begin
    avl_rdata_valid <= 1'b0;
    if (rst)
    begin
      avl_ready <= 1'b0;
      rd_cnt    <= 0;
    end
    else
    begin
      avl_ready <= (take_bits(2) != 0);
      if (avl_ready && avl_write)
      begin
        if (!mem_model.exists(avl_addr))
          mem_model[avl_addr] = fill_pattern(avl_addr);
        for (int b = 0; b < LINE_BYTES; b++)
          if (avl_be[b])
            mem_model[avl_addr][b*8 +: 8] = avl_wdata[b*8 +: 8];
      end
      if (avl_ready && avl_read)
      begin
        rd_addr <= avl_addr;
        rd_cnt  <= 1 + take_bits(2);
      end
      else if (rd_cnt != 0)
      begin
        if (rd_cnt == 1)
        begin
          avl_rdata_valid <= 1'b1;
          avl_rdata <= mem_model.exists(rd_addr) ? mem_model[rd_addr] : fill_pattern(rd_addr);
        end
        rd_cnt <= rd_cnt - 1;
      end
    end
  end

  task automatic wb_cycle(input bit on_data, input bit we, input logic [ADDR_W-1:0] adr,
                          input logic [WORD_W-1:0] dat, input logic [SEL_W-1:0] sel,
                          output logic [WORD_W-1:0] rdat, output int lat);
    wb_req_t req;
    wb_rsp_t rsp;
    req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    if (on_data)
      data_wb <= req;
    else
      inst_wb <= req;
    lat = -1;
    do
    begin
      @(posedge clk);
      lat++;
      rsp = on_data ? data_rsp : inst_rsp;
    end
    while (!rsp.ack);
    rdat = rsp.dat;
    if (on_data)
      data_wb <= '0;
    else
      inst_wb <= '0;
    @(posedge clk);
  endtask

  task automatic read_check(input bit on_data, input logic [ADDR_W-1:0] adr,
                            input bit expect_hit);
    logic [LINE_W-1:0] line;
    logic [WORD_W-1:0] exp;
    logic [WORD_W-1:0] got;
    int                lat;
    string             sig;
    line = shadow_line(adr);
    exp  = line[adr[OFFS_W-1:2]*WORD_W +: WORD_W];
    sig  = on_data ? "data_wb_o.dat" : "inst_wb_o.dat";
    wb_cycle(on_data, 1'b0, adr, '0, '0, got, lat);
    checks++;
    assert (got === exp)
    else
    begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, sig, exp, got);
      errors++;
    end
    if (expect_hit)
    begin
      checks++;
      assert (lat == HIT_LAT)
      else
      begin
        $display("hit on address %h acked after %0d cycles, not %0d", adr, lat, HIT_LAT);
        errors++;
      end
    end
  endtask

  task automatic write_word(input bit on_data, input logic [ADDR_W-1:0] adr,
                            input logic [WORD_W-1:0] dat, input logic [SEL_W-1:0] sel);
    logic [LINE_W-1:0] line;
    logic [WORD_W-1:0] unused_dat;
    int                lat;
    wb_cycle(on_data, 1'b1, adr, dat, sel, unused_dat, lat);
    if (on_data)  // instruction port drops writes.
    begin
      line = shadow_line(adr);
      for (int b = 0; b < SEL_W; b++)
        if (sel[b])
          line[adr[OFFS_W-1:2]*WORD_W + b*8 +: 8] = dat[b*8 +: 8];
      shadow[AVL_ADDR_W'(adr[ADDR_W-1:OFFS_W])] = line;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name, checks - chk_base,
             errors - err_base);
    chk_base = checks;
    err_base = errors;
  endtask

  initial
  begin
    repeat (NUM_TESTS * 400) @(posedge clk);
    $display("watchdog: run still busy after %0d cycles", NUM_TESTS * 400);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    clk             = 1'b0;
    rst             = 1'b1;
    inst_wb         = '0;
    data_wb         = '0;
    avl_ready       = 1'b0;
    avl_rdata_valid = 1'b0;
    avl_rdata       = '0;
    rd_cnt          = 0;
    lfsr_state      = 32'hd345_a37b;
    errors          = 0;
    checks          = 0;
    err_base        = 0;
    chk_base        = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    read_check(1'b0, 28'h000_0104, 1'b0);
    read_check(1'b0, 28'h000_0108, 1'b1);
    read_check(1'b1, 28'h000_0230, 1'b0);
    read_check(1'b1, 28'h000_023c, 1'b1);
    finish_test(1, "miss then hit");

    write_word(1'b1, 28'h000_0234, 32'ha1b2_c3d4, 4'b0101);
    read_check(1'b1, 28'h000_0234, 1'b1);  // cached line took the bytes.
    read_check(1'b0, 28'h000_0234, 1'b0);
    write_word(1'b1, 28'h000_0508, 32'h1122_3344, 4'b1100);
    read_check(1'b0, 28'h000_0508, 1'b0);
    read_check(1'b1, 28'h000_0508, 1'b0);
    finish_test(2, "partial writes");

    for (int i = 0; i < 4; i++)
      read_check(1'b0, i[0] ? 28'h002_0040 : 28'h001_0040, 1'b0);
    finish_test(3, "eviction");

    for (int i = 0; i < 4; i++)
    begin
      fork
        read_check(1'b0, 28'h003_0010 + 28'(i * 'h100), 1'b0);
        read_check(1'b1, 28'h004_0020 + 28'(i * 'h100), 1'b0);
      join
    end
    finish_test(4, "concurrent misses");

    write_word(1'b0, 28'h000_0600, 32'hdead_beef, 4'hf);
    read_check(1'b1, 28'h000_0600, 1'b0);
    finish_test(5, "instruction port write");

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", NUM_TESTS, checks,
             errors, DUT.chk.fail_cnt);
    if (errors == 0 && DUT.chk.fail_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: verilog.f
verilog/ddr3_pkg.sv
verilog/line_cache.sv
verilog/line_arbiter.sv
verilog/avl_master.sv
verilog/ddr3_frontend.sv
verif/ddr3_frontend_asserts.sv
verif/ddr3_frontend_tb.sv
